//--- rtl/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Clock and line rates
////////////////////////////////////////////////////////////////////////////

// System clock in Hz
`define UART_FCLK 1843200

// Line rate in bit/s
`define UART_BAUD 115200

// Clocks per bit, rounded to nearest
`define UART_DIVIDER ((`UART_FCLK + (`UART_BAUD / 2)) / `UART_BAUD)

////////////////////////////////////////////////////////////////////////////
// Frame format
////////////////////////////////////////////////////////////////////////////

// Data bits in every frame, sent LSB first
`define UART_DATA_BITS 8

`endif

//--- rtl/serialPkg.sv
`default_nettype none

`include "uart_defines.svh"

// Line side types, shared by receiver, transmitter and hold register
package serialPkg;

	// Bit timer, counts 0 .. divider-1
	typedef logic [$clog2(`UART_DIVIDER)-1:0] divCountT;

	// Transmit bits still to go (start + data + stop bits)
	typedef logic [3:0] bitCountT;

	// Received data bits with the stop bit on top
	typedef logic [`UART_DATA_BITS:0] frameWordT;

	// Transmit FSM
	typedef enum logic {
		TxIdle,    // Line high, ready for a byte
		TxSending  // Frame on the line
	} txStateT;

endpackage

`default_nettype wire

//--- rtl/hostPkg.sv
`default_nettype none

`include "uart_defines.svh"

// Host side types
package hostPkg;

	// One character as seen by the host
	typedef logic [`UART_DATA_BITS-1:0] dataByteT;

	// Receive flag pair
	// Bit 0 data valid, bit 1 overrun
	typedef logic [1:0] rxStatusT;

endpackage

`default_nettype wire

//--- rtl/uartRx.sv
`default_nettype none

`include "uart_defines.svh"

module uartRx #(
	parameter int Divider = `UART_DIVIDER  // Clocks per bit
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 rxd,          // Raw serial line
	output logic                 frameStrobe,  // One cycle, frame complete
	output serialPkg::frameWordT frameWord     // Data bits plus stop bit
);
	import serialPkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Line synchroniser
	////////////////////////////////////////////////////////////////////////////

	logic [1:0] rxSync;    // [1] is the older sample
	logic       lineEdge;  // Any transition of the synced line

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxSync <= 2'b11;  // Idle line is high
		end else begin
			rxSync <= {rxSync[0], rxd};
		end
	end

	assign lineEdge = rxSync[1] ^ rxSync[0];

	////////////////////////////////////////////////////////////////////////////
	// Bit timer
	////////////////////////////////////////////////////////////////////////////

	// Restarted by every edge so the sample point tracks the sender clock
	divCountT rxDiv;
	logic     rxDivMax;
	logic     rxSample;

	assign rxDivMax = (rxDiv == divCountT'(Divider - 1));
	assign rxSample = (rxDiv == divCountT'(Divider / 2 - 1));  // Mid-bit

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxDiv <= '0;
		end else if (lineEdge || rxDivMax) begin
			rxDiv <= '0;
		end else begin
			rxDiv <= rxDiv + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Receive shift register
	////////////////////////////////////////////////////////////////////////////

	// Samples enter at the top and walk down
	// The start bit (low) reaching bit 0 marks a full frame:
	// [9] stop, [8:1] data, [0] start
	logic [`UART_DATA_BITS+1:0] rxShift;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxShift <= '1;
		end else if (!rxShift[0]) begin
			rxShift <= '1;  // Frame taken, look for the next start bit
		end else if (rxSample) begin
			rxShift <= {rxSync[1], rxShift[`UART_DATA_BITS+1:1]};
		end
	end

	// Strobe lasts one cycle since the register is preset right after
	assign frameStrobe = ~rxShift[0];
	assign frameWord   = frameWordT'(rxShift[`UART_DATA_BITS+1:1]);

endmodule

`default_nettype wire

//--- rtl/rxHoldBuffer.sv
`default_nettype none

`include "uart_defines.svh"

module rxHoldBuffer (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 frameStrobe,   // New frame from receiver
	input  serialPkg::frameWordT frameWord,
	input  logic                 rxReady,       // Host takes the entry
	output logic                 rxValid,
	output hostPkg::dataByteT    rxData,
	output logic                 rxFrameError,  // Stored stop bit was low
	output logic                 rxOverrun      // A frame got overwritten
);
	import serialPkg::*;
	import hostPkg::*;

	frameWordT holdWord;  // Last frame, data and stop
	rxStatusT  rxFlags;   // {overrun, valid}
	logic      hostTake;  // Host transfer this edge

	assign hostTake = rxValid & rxReady;

	// Payload register, always written by a new frame
	always_ff @(posedge clk) begin
		if (frameStrobe) begin
			holdWord <= frameWord;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Valid / overrun pair
	////////////////////////////////////////////////////////////////////////////

	// New frame shifts valid into the overrun slot
	// A transfer on the same edge means nothing was lost
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxFlags <= '0;
		end else if (frameStrobe) begin
			rxFlags <= {rxFlags[0] & ~hostTake, 1'b1};
		end else if (hostTake) begin
			rxFlags <= '0;  // Read clears both
		end
	end

	assign rxValid      = rxFlags[0];
	assign rxOverrun    = rxFlags[1];
	assign rxData       = dataByteT'(holdWord[`UART_DATA_BITS-1:0]);
	assign rxFrameError = ~holdWord[`UART_DATA_BITS];  // Stop bit on top

endmodule

`default_nettype wire

//--- rtl/uartTx.sv
`default_nettype none

`include "uart_defines.svh"

module uartTx #(
	parameter int Divider = `UART_DIVIDER  // Clocks per bit
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              nstop,    // 1 for two stop bits
	input  logic              txValid,  // Host has a byte
	input  hostPkg::dataByteT txData,
	output logic              txd,      // Serial line
	output logic              txReady   // High only while idle
);
	import serialPkg::*;

	txStateT  txState;
	divCountT txDiv;
	bitCountT bitCount;   // Bits left including stop bits
	logic     accept;     // Byte handshake this edge
	logic     bitEnd;     // Last clock of the current bit
	logic     lastBit;

	logic [`UART_DATA_BITS:0] txShift;  // Data plus start bit, LSB on the line

	assign txReady = (txState == TxIdle);
	assign accept  = txValid & txReady;
	assign bitEnd  = (txDiv == divCountT'(Divider - 1));
	assign lastBit = (bitCount == bitCountT'(1));

	////////////////////////////////////////////////////////////////////////////
	// Bit timer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			txDiv <= '0;
		end else if (accept || bitEnd) begin
			txDiv <= '0;  // Realigned to the accepting edge
		end else begin
			txDiv <= txDiv + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Shift register and bit counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			txShift <= '1;  // Line idles high
		end else if (accept) begin
			txShift <= {txData, 1'b0};  // Start bit goes out first
		end else if (bitEnd) begin
			txShift <= {1'b1, txShift[`UART_DATA_BITS:1]};  // Ones become stop bits
		end
	end

	assign txd = txShift[0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			bitCount <= '0;
		end else if (accept) begin
			bitCount <= {3'b101, nstop};  // 10 or 11 bit times
		end else if (bitEnd && bitCount != '0) begin
			bitCount <= bitCount - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			txState <= TxIdle;
		end else begin
			case (txState)
				TxIdle:    if (accept) txState <= TxSending;
				TxSending: if (bitEnd && lastBit) txState <= TxIdle;  // Counter hits zero
				default:   txState <= TxIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/uartTop.sv
`default_nettype none

`include "uart_defines.svh"

module uartTop #(
	parameter int Divider = `UART_DIVIDER  // Clocks per bit
) (
	input  logic              clk,
	input  logic              reset,
	// Serial side
	input  logic              rxd,
	output logic              txd,
	input  logic              nstop,         // 1 selects two stop bits
	// Host write
	input  logic              txValid,
	input  hostPkg::dataByteT txData,
	output logic              txReady,
	// Host read
	output logic              rxValid,
	output hostPkg::dataByteT rxData,
	output logic              rxFrameError,
	output logic              rxOverrun,
	input  logic              rxReady
);
	import serialPkg::*;

	// Receiver to hold register, no back-pressure possible
	logic      frameStrobe;
	frameWordT frameWord;

	uartRx #(
		.Divider(Divider)
	) rxUnit (
		.clk        (clk),
		.reset      (reset),
		.rxd        (rxd),
		.frameStrobe(frameStrobe),
		.frameWord  (frameWord)
	);

	rxHoldBuffer holdBuffer (
		.clk         (clk),
		.reset       (reset),
		.frameStrobe (frameStrobe),
		.frameWord   (frameWord),
		.rxReady     (rxReady),
		.rxValid     (rxValid),
		.rxData      (rxData),
		.rxFrameError(rxFrameError),
		.rxOverrun   (rxOverrun)
	);

	// Transmitter fed straight from the host
	uartTx #(
		.Divider(Divider)
	) txUnit (
		.clk    (clk),
		.reset  (reset),
		.nstop  (nstop),
		.txValid(txValid),
		.txData (txData),
		.txd    (txd),
		.txReady(txReady)
	);

endmodule

`default_nettype wire

//--- dv/uartTb_sva.sv
`default_nettype none

// Protocol checks on the host and serial ports of uartTop
module uartTbSva (
	input logic              clk,
	input logic              reset,
	input logic              txValid,
	input logic              txReady,
	input hostPkg::dataByteT txData,
	input logic              txd,
	input logic              rxValid,
	input logic              rxReady,
	input logic              frameStrobe,   // Receiver writes the hold register
	input hostPkg::dataByteT rxData,
	input logic              rxFrameError
);
	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;  // Assertion failures so far

	// Host holds its byte under back-pressure
	txDataHeld: assert property (@(posedge clk) disable iff (reset)
		txValid && !txReady |=> $stable(txData))
		else begin
			$error("txData changed while txValid waited for txReady");
			failCount++;
		end

	// Unread entry only changes when a new frame lands
	rxDataHeld: assert property (@(posedge clk) disable iff (reset)
		rxValid && !rxReady && !frameStrobe |=> $stable(rxData) && $stable(rxFrameError))
		else begin
			$error("rxData changed while rxValid waited for rxReady");
			failCount++;
		end

	// Idle transmitter keeps the line high
	txdIdleHigh: assert property (@(posedge clk) disable iff (reset)
		txReady |-> txd)
		else begin
			$error("txd low while txReady high");
			failCount++;
		end

endmodule

bind uartTop uartTbSva protocolChecks (
	.clk         (clk),
	.reset       (reset),
	.txValid     (txValid),
	.txReady     (txReady),
	.txData      (txData),
	.txd         (txd),
	.rxValid     (rxValid),
	.rxReady     (rxReady),
	.frameStrobe (frameStrobe),
	.rxData      (rxData),
	.rxFrameError(rxFrameError)
);

`default_nettype wire

//--- dv/uartTb.sv
`default_nettype none

`include "uart_defines.svh"

module uartTb;
	timeunit 1ns;
	timeprecision 100ps;

	import hostPkg::*;

	localparam int Divider     = `UART_DIVIDER;
	localparam int ClockPeriod = 8;
	localparam int ResetCycles = 8;
	localparam int Seed        = 86;
	localparam int NumTx       = 6;   // Bytes sent through the transmitter
	localparam int NumRx       = 8;   // Good frames sent to the receiver
	localparam int TxTimeout   = 14 * Divider;
	localparam int RxTimeout   = 14 * Divider;

	logic     clk;
	logic     reset;
	logic     rxd;
	logic     nstop;
	logic     txValid;
	dataByteT txData;
	logic     rxReady;
	logic     txd;
	logic     txReady;
	logic     rxValid;
	dataByteT rxData;
	logic     rxFrameError;
	logic     rxOverrun;

	int errorCount;
	int checkCount;

	dataByteT    txBytes [NumTx];
	logic        txStops [NumTx];     // nstop per byte
	int          busyCycles [$];      // txReady low time per frame
	logic [10:0] capturedFrames [$];  // txd samples with bit 0 first

	always #(ClockPeriod / 2) clk = ~clk;

	uartTop #(
		.Divider(Divider)
	) u_dut (
		.clk         (clk),
		.reset       (reset),
		.rxd         (rxd),
		.txd         (txd),
		.nstop       (nstop),
		.txValid     (txValid),
		.txData      (txData),
		.txReady     (txReady),
		.rxValid     (rxValid),
		.rxData      (rxData),
		.rxFrameError(rxFrameError),
		.rxOverrun   (rxOverrun),
		.rxReady     (rxReady)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Host view of the newest frame as {overrun, frameError, data}
	function automatic logic [9:0] expectedRx(input dataByteT data, input logic stopBit,
			input int unread);
		logic overrun;
		overrun = (unread > 1);  // An older unread frame was overwritten
		return {overrun, ~stopBit, data};
	endfunction

	// Line levels in send order
	// Bit 10 holds the second stop bit when there is one
	function automatic logic [10:0] expectedTxBits(input dataByteT data);
		logic [10:0] bits;
		bits    = '1;    // Stop bits high
		bits[0] = 1'b0;  // Start
		for (int i = 0; i < `UART_DATA_BITS; i++) begin
			bits[i + 1] = data[i];  // LSB first
		end
		return bits;
	endfunction

	// Clocks from acceptance until txReady returns
	function automatic int frameCycles(input logic twoStop);
		return (2 + `UART_DATA_BITS + int'(twoStop)) * Divider;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checking and end of run
	////////////////////////////////////////////////////////////////////////////

	task automatic checkValue(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		assert (actual === expected) else begin
			errorCount++;
			$display("FAILED %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic finishRun();
		errorCount += u_dut.protocolChecks.failCount;
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	endtask

	task automatic reportTimeout(input string reason);
		errorCount++;
		$display("Timed out at %0d ns: %s", $time, reason);
	endtask

	// Compare the hold register with the model
	task automatic checkRx(input string what, input dataByteT data, input logic stopBit,
			input int unread);
		logic [9:0] expected;
		expected = expectedRx(data, stopBit, unread);
		checkValue({what, " rxValid"}, rxValid, 1'b1);
		checkValue({what, " rxData"}, rxData, expected[7:0]);
		checkValue({what, " rxFrameError"}, rxFrameError, expected[8]);
		checkValue({what, " rxOverrun"}, rxOverrun, expected[9]);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Line model and host side
	////////////////////////////////////////////////////////////////////////////

	// One frame on rxd followed by two idle bit times
	task automatic sendRxFrame(input dataByteT data, input logic stopBit);
		logic [9:0] bits;
		bits = {stopBit, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rxd = bits[i];
			repeat (Divider) @(negedge clk);
		end
		rxd = 1'b1;
		repeat (2 * Divider) @(negedge clk);
	endtask

	task automatic waitRxValid();
		int cycles;
		cycles = 0;
		while (!rxValid && cycles < RxTimeout) begin
			@(negedge clk);
			cycles++;
		end
		if (!rxValid) reportTimeout("rxValid never rose after a frame");
	endtask

	// One-cycle read with the transfer on the rising edge in between
	task automatic readRx();
		rxReady = 1'b1;
		@(negedge clk);
		rxReady = 1'b0;
	endtask

	task automatic waitTxReady(output int busy);
		busy = 0;
		while (!txReady && busy < TxTimeout) begin
			@(negedge clk);
			busy++;
		end
		if (!txReady) reportTimeout("transmitter never raised txReady");
	endtask

	task automatic waitTxStart();
		int cycles;
		cycles = 0;
		while (txd && cycles < TxTimeout) begin
			@(negedge clk);
			cycles++;
		end
		if (txd) reportTimeout("no start bit appeared on txd");
	endtask

	// Next byte is presented while the previous frame still runs
	task automatic driveTxBytes();
		int busy;
		for (int i = 0; i <= NumTx; i++) begin
			if (i < NumTx) begin
				txValid = 1'b1;  // Held until accepted
				txData  = txBytes[i];
				nstop   = txStops[i];
			end else begin
				txValid = 1'b0;
			end
			waitTxReady(busy);
			if (i > 0) busyCycles.push_back(busy);  // Busy time of frame i-1
			if (i < NumTx) @(negedge clk);
		end
	endtask

	// Samples txd at mid-bit from each falling start edge
	task automatic captureTxFrames();
		logic [10:0] bits;
		int          nBits;
		for (int f = 0; f < NumTx; f++) begin
			waitTxStart();
			repeat (Divider / 2) @(negedge clk);  // Middle of the start bit
			bits  = '1;
			nBits = 2 + `UART_DATA_BITS + int'(txStops[f]);
			for (int b = 0; b < nBits; b++) begin
				if (b > 0) repeat (Divider) @(negedge clk);
				bits[b] = txd;
			end
			capturedFrames.push_back(bits);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		dataByteT firstByte;
		dataByteT secondByte;
		int       unread;
		errorCount = 0;
		checkCount = 0;
		clk        = 1'b0;
		reset      = 1'b1;
		rxd        = 1'b1;  // Idle line
		nstop      = 1'b0;
		txValid    = 1'b0;
		txData     = '0;
		rxReady    = 1'b0;
		void'($urandom(Seed));
		repeat (ResetCycles) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		// Idle state out of reset
		checkValue("txd after reset", txd, 1'b1);
		checkValue("txReady after reset", txReady, 1'b1);
		checkValue("rxValid after reset", rxValid, 1'b0);
		checkValue("rxOverrun after reset", rxOverrun, 1'b0);

		// Transmit with alternating one and two stop bits
		for (int i = 0; i < NumTx; i++) begin
			txBytes[i] = dataByteT'($urandom);
			txStops[i] = logic'(i % 2);
		end
		fork
			driveTxBytes();
			captureTxFrames();
		join
		checkValue("frames seen on txd", capturedFrames.size(), NumTx);
		checkValue("frames accepted", busyCycles.size(), NumTx);
		for (int i = 0; i < NumTx; i++) begin
			checkValue("txd frame", capturedFrames[i], expectedTxBits(txBytes[i]));
			checkValue("txReady low cycles", busyCycles[i], frameCycles(txStops[i]));
		end

		// Good frames that are read right away
		unread = 0;
		for (int i = 0; i < NumRx; i++) begin
			firstByte = dataByteT'($urandom);
			sendRxFrame(firstByte, 1'b1);
			unread++;
			waitRxValid();
			checkRx("good frame", firstByte, 1'b1, unread);
			readRx();
			unread = 0;
			checkValue("rxValid after read", rxValid, 1'b0);
		end

		// Low stop bit
		firstByte = dataByteT'($urandom);
		sendRxFrame(firstByte, 1'b0);
		unread = 1;
		waitRxValid();
		checkRx("bad stop frame", firstByte, 1'b0, unread);
		readRx();
		unread = 0;
		checkValue("rxValid after bad frame read", rxValid, 1'b0);

		// Held entry and then overrun by a second frame
		firstByte  = dataByteT'($urandom);
		secondByte = dataByteT'($urandom);
		sendRxFrame(firstByte, 1'b1);
		unread = 1;
		waitRxValid();
		checkRx("held frame", firstByte, 1'b1, unread);
		repeat (3 * Divider) @(negedge clk);
		checkRx("held frame later", firstByte, 1'b1, unread);
		sendRxFrame(secondByte, 1'b1);
		unread = 2;
		waitRxValid();
		checkRx("overrun frame", secondByte, 1'b1, unread);
		readRx();
		checkValue("rxValid after overrun read", rxValid, 1'b0);
		checkValue("rxOverrun after read", rxOverrun, 1'b0);

		finishRun();
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
rtl/serialPkg.sv
rtl/hostPkg.sv
rtl/uartRx.sv
rtl/rxHoldBuffer.sv
rtl/uartTx.sv
rtl/uartTop.sv
dv/uartTb_sva.sv
dv/uartTb.sv

//--- Bender.yml
package:
  name: uart

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/serialPkg.sv
      - rtl/hostPkg.sv
      - rtl/uartRx.sv
      - rtl/rxHoldBuffer.sv
      - rtl/uartTx.sv
      - rtl/uartTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/uartTb_sva.sv
      - dv/uartTb.sv
